// ==== verilog/sched_defs.svh ====
`ifndef SCHED_DEFS_SVH
`define SCHED_DEFS_SVH

// core ports
`define SCHED_NUM_CORE  4
`define SCHED_CORE_W    2

// logical processes
`define SCHED_NUM_LP    8
`define SCHED_LP_W      3

// event word layout
`define SCHED_TIME_W    16
`define SCHED_KEY_W     17   // time plus polarity bit
`define SCHED_MSG_W     32

// pending event queue
`define SCHED_Q_DEPTH   16
`define SCHED_Q_CNT_W   5

// run stops once gvt goes beyond this
`define SCHED_END_TIME  200

`endif

// ==== verilog/sched_pkg.sv ====
`include "sched_defs.svh"

package sched_pkg;

   // event as the cores and the gvt logic see it
   typedef struct packed {
      logic [`SCHED_TIME_W-1:0]                                 ev_time;
      logic                                                     pos;     // 0 = anti-message
      logic [`SCHED_LP_W-1:0]                                   lp;
      logic [`SCHED_MSG_W-`SCHED_TIME_W-`SCHED_LP_W-2:0]        spare;
   } event_t;

   // same word seen by the sorted queue
   typedef struct packed {
      logic [`SCHED_KEY_W-1:0]                  key;     // {time, pos}
      logic [`SCHED_MSG_W-`SCHED_KEY_W-1:0]     payload;
   } event_key_t;

   // anti-message has pos clear, so it sorts ahead at equal time
   typedef union packed {
      event_t     ev;
      event_key_t kv;
   } event_msg_u;

   typedef struct packed {
      logic       has_event;   // clear for a null result
      event_msg_u msg;
   } core_result_t;

   typedef enum logic [2:0] {
      IDLE,
      INIT,
      RUNNING,
      FINISHED,
      HALT
   } sched_phase_e;

endpackage

// ==== verilog/rr_arbiter.sv ====
`timescale 1ns/100ps
`include "sched_defs.svh"

module rr_arbiter (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic [`SCHED_NUM_CORE-1:0] req,
   input  logic                       advance,
   output logic                       grant_vld,
   output logic [`SCHED_CORE_W-1:0]   grant_idx
);

   localparam int CW = `SCHED_CORE_W;

   logic [CW-1:0] grant_q;
   logic [CW-1:0] ptr_q;      // search starts here
   logic [CW-1:0] cand;
   logic [CW-1:0] pick;
   logic          pick_vld;

   // first requester at or after the pointer
   always_comb begin
      pick     = ptr_q;
      pick_vld = 1'b0;
      cand     = ptr_q;
      for (int i = 0; i < `SCHED_NUM_CORE; i++) begin
         cand = ptr_q + CW'(i);
         if (!pick_vld && req[cand]) begin
            pick     = cand;
            pick_vld = 1'b1;
         end
      end
   end

   // reload when the holder is served or has dropped its request
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         grant_q <= '0;
         ptr_q   <= '0;
      end else if ((advance || !req[grant_q]) && pick_vld) begin
         grant_q <= pick;
         ptr_q   <= pick + 1'b1;   // rotate past the new holder
      end
   end

   assign grant_vld = req[grant_q];
   assign grant_idx = grant_q;

endmodule

// ==== verilog/event_queue.sv ====
`timescale 1ns/100ps
`include "sched_defs.svh"

module event_queue (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  enq,
   input  logic                  deq,
   input  sched_pkg::event_msg_u in_msg,
   output sched_pkg::event_msg_u head_msg,
   output logic                  empty,
   output logic                  full
);

   import sched_pkg::*;

   event_msg_u                slot [`SCHED_Q_DEPTH];
   logic [`SCHED_Q_CNT_W-1:0] count;
   logic [`SCHED_Q_DEPTH-1:0] keep;     // slot holds on insert
   logic                      do_enq;
   logic                      do_deq;

   assign do_enq = enq && !full;
   assign do_deq = deq && !empty;

   // valid entries with key not above the new one stay in place
   // equal keys keep arrival order
   always_comb begin
      for (int i = 0; i < `SCHED_Q_DEPTH; i++) begin
         keep[i] = (i < count) && (slot[i].kv.key <= in_msg.kv.key);
      end
   end

   always_ff @(posedge clk) begin
      if (do_enq) begin
         if (!keep[0]) begin
            slot[0] <= in_msg;
         end
         for (int i = 1; i < `SCHED_Q_DEPTH; i++) begin
            if (!keep[i]) begin
               if (keep[i-1]) begin
                  slot[i] <= in_msg;      // opened slot
               end else begin
                  slot[i] <= slot[i-1];   // push toward the tail
               end
            end
         end
      end else if (do_deq) begin
         // whole array moves one step toward the head
         for (int i = 0; i < `SCHED_Q_DEPTH - 1; i++) begin
            slot[i] <= slot[i+1];
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         count <= '0;
      end else if (do_enq) begin
         count <= count + 1'b1;
      end else if (do_deq) begin
         count <= count - 1'b1;
      end
   end

   assign head_msg = slot[0];
   assign empty    = (count == 0);
   assign full     = (count == `SCHED_Q_DEPTH);

endmodule

// ==== verilog/core_tracker.sv ====
`timescale 1ns/100ps
`include "sched_defs.svh"

module core_tracker (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic [`SCHED_NUM_CORE-1:0] disp_vld,
   input  sched_pkg::event_msg_u      disp_msg,
   input  logic [`SCHED_NUM_CORE-1:0] res_ack,
   output logic [`SCHED_TIME_W-1:0]   busy_min,
   output logic                       busy_any
);

   import sched_pkg::*;

   localparam int N = `SCHED_NUM_CORE;

   logic [N-1:0]               busy;
   logic [`SCHED_TIME_W-1:0]   btime [N];       // time of the event in work
   logic [`SCHED_TIME_W-1:0]   node  [2*N-1];   // min tree, leaves at the top end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         busy <= '0;
      end else begin
         for (int i = 0; i < N; i++) begin
            if (disp_vld[i]) begin
               busy[i] <= 1'b1;
            end else if (res_ack[i]) begin
               busy[i] <= 1'b0;   // result taken back
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < N; i++) begin
         if (disp_vld[i]) begin
            btime[i] <= disp_msg.ev.ev_time;
         end
      end
   end

   // idle cores drop out as all ones
   always_comb begin
      for (int i = 0; i < N; i++) begin
         node[N-1+i] = busy[i] ? btime[i] : '1;
      end
      for (int k = N - 2; k >= 0; k--) begin
         node[k] = (node[2*k+1] < node[2*k+2]) ? node[2*k+1] : node[2*k+2];
      end
   end

   assign busy_min = node[0];
   assign busy_any = |busy;

endmodule

// ==== verilog/gvt_unit.sv ====
`timescale 1ns/100ps
`include "sched_defs.svh"

module gvt_unit (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     running,
   input  sched_pkg::event_msg_u    head_msg,
   input  logic                     q_empty,
   input  logic [`SCHED_TIME_W-1:0] busy_min,
   input  logic                     busy_any,
   output logic [`SCHED_TIME_W-1:0] gvt,
   output logic                     past_end
);

   import sched_pkg::*;

   logic [`SCHED_TIME_W-1:0] head_time;
   logic [`SCHED_TIME_W-1:0] cand;
   logic                     load;

   assign head_time = head_msg.ev.ev_time;

   // lesser of the minimums that are valid
   always_comb begin
      if (!q_empty && busy_any) begin
         cand = (head_time < busy_min) ? head_time : busy_min;
      end else if (!q_empty) begin
         cand = head_time;
      end else begin
         cand = busy_min;
      end
   end

   // nothing pending anywhere, so gvt holds
   assign load = running && (!q_empty || busy_any);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         gvt      <= '0;
         past_end <= 1'b0;
      end else begin
         past_end <= load && (cand > `SCHED_END_TIME);
         if (load) begin
            gvt <= cand;
         end
      end
   end

endmodule

// ==== verilog/sched_ctrl.sv ====
`timescale 1ns/100ps
`include "sched_defs.svh"

module sched_ctrl (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  past_end,
   input  logic                  q_full,
   input  logic                  q_empty,
   input  logic                  rcv_vld,
   input  logic                  disp_ok,
   output logic                  enq,
   output logic                  deq,
   output sched_pkg::event_msg_u seed_msg,
   output logic                  seeding,
   output logic                  running,
   output logic                  done
);

   import sched_pkg::*;

   sched_phase_e           phase;
   sched_phase_e           phase_nxt;
   logic [`SCHED_LP_W-1:0] init_cnt;   // next lp to seed
   logic                   q_busy;     // idle cycle after a queue op

   assign seeding = (phase == INIT);
   assign running = (phase == RUNNING);
   assign done    = (phase == FINISHED);

   // enqueue has priority over dequeue
   assign enq = !q_busy && (seeding || (running && rcv_vld && !q_full));
   assign deq = !q_busy && running && !enq && !q_empty && disp_ok;

   always_comb begin
      phase_nxt = phase;
      case (phase)
         IDLE: begin
            phase_nxt = INIT;
         end
         INIT: begin
            if (enq && init_cnt == `SCHED_NUM_LP - 1) begin
               phase_nxt = RUNNING;   // last seed going in
            end
         end
         RUNNING: begin
            if (past_end) begin
               phase_nxt = FINISHED;
            end
         end
         FINISHED: begin
            phase_nxt = HALT;
         end
         default: begin
            phase_nxt = HALT;   // stays here until reset
         end
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         phase    <= IDLE;
         q_busy   <= 1'b0;
         init_cnt <= '0;
      end else begin
         phase  <= phase_nxt;
         q_busy <= enq || deq;
         if (seeding && enq) begin
            init_cnt <= init_cnt + 1'b1;
         end
      end
   end

   // time zero positive event per lp
   always_comb begin
      seed_msg        = '0;
      seed_msg.ev.pos = 1'b1;
      seed_msg.ev.lp  = init_cnt;
   end

endmodule

// ==== verilog/event_sched.sv ====
`timescale 1ns/100ps
`include "sched_defs.svh"

module event_sched (
   input  logic                                          clk,
   input  logic                                          rst_n,
   input  logic [`SCHED_NUM_CORE-1:0]                    core_rdy,
   input  logic [`SCHED_NUM_CORE-1:0]                    res_vld,
   input  sched_pkg::core_result_t [`SCHED_NUM_CORE-1:0] res,
   output logic [`SCHED_NUM_CORE-1:0]                    disp_vld,
   output sched_pkg::event_msg_u                         disp_msg,
   output logic [`SCHED_NUM_CORE-1:0]                    res_ack,
   output logic [`SCHED_TIME_W-1:0]                      gvt,
   output logic                                          done
);

   import sched_pkg::*;

   logic                     rcv_vld;
   logic [`SCHED_CORE_W-1:0] rcv_idx;
   logic                     disp_ok;
   logic [`SCHED_CORE_W-1:0] disp_idx;
   logic                     enq;
   logic                     deq;
   logic                     rcv_enq;    // enq serving a core result
   logic                     q_enq;
   logic                     seeding;
   logic                     running;
   logic                     past_end;
   logic                     q_full;
   logic                     q_empty;
   logic [`SCHED_TIME_W-1:0] busy_min;
   logic                     busy_any;
   core_result_t             rcv_res;
   event_msg_u               seed_msg;
   event_msg_u               q_in;
   event_msg_u               head_msg;

   assign rcv_res = res[rcv_idx];
   assign rcv_enq = enq && !seeding;
   assign q_in    = seeding ? seed_msg : rcv_res.msg;
   assign q_enq   = enq && (seeding || rcv_res.has_event);   // null results are acked only

   // one-hot pulses for the granted cores
   always_comb begin
      for (int i = 0; i < `SCHED_NUM_CORE; i++) begin
         disp_vld[i] = deq && (disp_idx == i);
         res_ack[i]  = rcv_enq && (rcv_idx == i);
      end
   end

   assign disp_msg = head_msg;   // broadcast, only the pulsed core takes it

   rr_arbiter rcv_arb (
      .clk       (clk),
      .rst_n     (rst_n),
      .req       (res_vld),
      .advance   (rcv_enq),
      .grant_vld (rcv_vld),
      .grant_idx (rcv_idx)
   );

   rr_arbiter disp_arb (
      .clk       (clk),
      .rst_n     (rst_n),
      .req       (core_rdy),
      .advance   (deq),
      .grant_vld (disp_ok),
      .grant_idx (disp_idx)
   );

   event_queue u_queue (
      .clk      (clk),
      .rst_n    (rst_n),
      .enq      (q_enq),
      .deq      (deq),
      .in_msg   (q_in),
      .head_msg (head_msg),
      .empty    (q_empty),
      .full     (q_full)
   );

   core_tracker u_tracker (
      .clk      (clk),
      .rst_n    (rst_n),
      .disp_vld (disp_vld),
      .disp_msg (head_msg),
      .res_ack  (res_ack),
      .busy_min (busy_min),
      .busy_any (busy_any)
   );

   gvt_unit u_gvt (
      .clk      (clk),
      .rst_n    (rst_n),
      .running  (running),
      .head_msg (head_msg),
      .q_empty  (q_empty),
      .busy_min (busy_min),
      .busy_any (busy_any),
      .gvt      (gvt),
      .past_end (past_end)
   );

   sched_ctrl u_ctrl (
      .clk      (clk),
      .rst_n    (rst_n),
      .past_end (past_end),
      .q_full   (q_full),
      .q_empty  (q_empty),
      .rcv_vld  (rcv_vld),
      .disp_ok  (disp_ok),
      .enq      (enq),
      .deq      (deq),
      .seed_msg (seed_msg),
      .seeding  (seeding),
      .running  (running),
      .done     (done)
   );

endmodule

// ==== bench/clk_gen.sv ====
`timescale 1ns/100ps

module clk_gen #(
   parameter int PERIOD = 40   // ns
) (
   output logic clk
);

   initial begin
      clk = 1'b0;
      forever begin
         #(PERIOD / 2) clk = ~clk;
      end
   end

endmodule

// ==== bench/tb_event_sched.sv ====
`timescale 1ns/100ps
`include "sched_defs.svh"

module tb_event_sched;

   import sched_pkg::*;

   localparam int NC         = `SCHED_NUM_CORE;
   localparam int MAX_LINES  = 13;
   localparam int SAMPLE_OFS = 10;     // ns after the falling edge
   localparam int RUN_LIMIT  = 6000;   // cycles allowed until done
   localparam int ACK_LIMIT  = 500;
   localparam int TAIL       = 20;     // cycles watched after done

   logic                     clk;
   logic                     rst_n;
   logic [NC-1:0]            core_rdy;
   logic [NC-1:0]            res_vld;
   core_result_t [NC-1:0]    res;
   logic [NC-1:0]            disp_vld;
   event_msg_u               disp_msg;
   logic [NC-1:0]            res_ack;
   logic [`SCHED_TIME_W-1:0] gvt;
   logic                     done;

   logic [15:0]              trace_mem [0:2+5*MAX_LINES-1];
   logic [15:0]              end_time;
   int                       n_lines;
   int                       next_line;

   event_msg_u               model_q [$];   // pending events, unordered
   logic [NC-1:0]            busy;
   logic [`SCHED_TIME_W-1:0] busy_time [NC];
   logic [`SCHED_NUM_LP-1:0] seen_lp;
   logic [`SCHED_TIME_W-1:0] last_gvt;

   int                       core_st [NC];  // 0 ready, 1 working, 2 holding result
   int                       delay_cnt [NC];
   int                       ack_wait [NC];
   core_result_t             pend [NC];
   event_msg_u               got_msg [NC];  // event taken in the dispatch cycle
   logic [NC-1:0]            got_disp;
   logic [NC-1:0]            got_ack;

   int  err_cnt, n_disp, n_acks, n_null, n_ties, cycles;
   bit  done_seen, aborted;

   clk_gen #(.PERIOD(40)) u_clk (.clk(clk));

   event_sched DUT (
      .clk      (clk),
      .rst_n    (rst_n),
      .core_rdy (core_rdy),
      .res_vld  (res_vld),
      .res      (res),
      .disp_vld (disp_vld),
      .disp_msg (disp_msg),
      .res_ack  (res_ack),
      .gvt      (gvt),
      .done     (done)
   );

   task automatic flag_error(input string msg);
      $display("error %0d ns: %s", $time, msg);
      err_cnt++;
   endtask

   // lowest time still pending in the queue model or on a busy core
   function automatic logic [31:0] lowest_time();
      logic [31:0] low;
      low = '1;
      foreach (model_q[k]) begin
         if (model_q[k].ev.ev_time < low) low = model_q[k].ev.ev_time;
      end
      for (int i = 0; i < NC; i++) begin
         if (busy[i] && busy_time[i] < low) low = busy_time[i];
      end
      return low;
   endfunction

   // next trace line turns the received event into a result
   task automatic start_work(input int i, input event_msg_u got);
      int         base;
      event_msg_u m;
      base      = 2 + 5 * next_line;
      next_line = (next_line + 1) % n_lines;
      m              = '0;
      m.ev.pos       = trace_mem[base+2][0];
      m.ev.lp        = got.ev.lp + trace_mem[base+3][`SCHED_LP_W-1:0];   // wraps over lps
      m.ev.ev_time   = got.ev.ev_time + trace_mem[base+4];
      pend[i].has_event = trace_mem[base+1][0];
      pend[i].msg    = m;
      delay_cnt[i]   = trace_mem[base];
      core_st[i]     = 1;
      core_rdy[i]    = 1'b0;
   endtask

   // core models, run at the falling edge
   task automatic update_cores();
      for (int i = 0; i < NC; i++) begin
         if (got_ack[i]) begin
            core_st[i]  = 0;
            res_vld[i]  = 1'b0;
            core_rdy[i] = 1'b1;
         end else if (got_disp[i]) begin
            start_work(i, got_msg[i]);
         end else if (core_st[i] == 1) begin
            if (delay_cnt[i] == 0) begin
               core_st[i]  = 2;
               res[i]      = pend[i];
               res_vld[i]  = 1'b1;
               ack_wait[i] = 0;
            end else begin
               delay_cnt[i]--;
            end
         end else if (core_st[i] == 2) begin
            ack_wait[i]++;
            if (ack_wait[i] > ACK_LIMIT) begin
               $display("core %0d waited %0d cycles and its result was never acknowledged",
                        i, ACK_LIMIT);
               err_cnt++;
               aborted = 1'b1;
            end
         end
      end
      got_ack  = '0;
      got_disp = '0;
   endtask

   task automatic check_dispatch(input int i);
      logic [`SCHED_KEY_W-1:0] best;
      int                      hit;
      if (model_q.size() == 0) begin
         flag_error($sformatf("core %0d got event %h with nothing pending", i, disp_msg));
         return;
      end
      best = model_q[0].kv.key;
      hit  = -1;
      foreach (model_q[k]) begin
         if (model_q[k].kv.key < best) best = model_q[k].kv.key;
         if (hit < 0 && model_q[k] == disp_msg) hit = k;
      end
      if (disp_msg.kv.key != best) begin
         flag_error($sformatf("dispatched key %h, lowest pending key %h", disp_msg.kv.key, best));
      end
      if (hit < 0) begin
         flag_error($sformatf("dispatched event %h was never pending", disp_msg));
      end else begin
         model_q.delete(hit);
      end
      if (!disp_msg.ev.pos) begin
         foreach (model_q[k]) begin   // a positive twin left behind
            if (model_q[k].ev.pos && model_q[k].ev.ev_time == disp_msg.ev.ev_time) n_ties++;
         end
      end
      if (n_disp < `SCHED_NUM_LP) begin
         if (disp_msg.ev.ev_time != 0 || !disp_msg.ev.pos || seen_lp[disp_msg.ev.lp]) begin
            flag_error($sformatf("seed dispatch %0d carries %h", n_disp, disp_msg));
         end
         seen_lp[disp_msg.ev.lp] = 1'b1;
      end
      n_disp++;
      busy[i]      = 1'b1;
      busy_time[i] = disp_msg.ev.ev_time;
      got_msg[i]   = disp_msg;
      got_disp[i]  = 1'b1;
   endtask

   // outputs are settled between the falling and the rising edge
   task automatic check_outputs();
      logic [31:0] low;
      low = lowest_time();
      if (gvt < last_gvt) flag_error($sformatf("gvt fell from %0d to %0d", last_gvt, gvt));
      if (gvt > low) flag_error($sformatf("gvt %0d above pending time %0d", gvt, low));
      last_gvt = gvt;
      if ((done_seen || done) && (disp_vld != 0 || res_ack != 0)) begin
         flag_error($sformatf("handshake after end, disp %b ack %b", disp_vld, res_ack));
      end
      if ((disp_vld & (disp_vld - 1'b1)) != 0 || (disp_vld & ~core_rdy) != 0) begin
         flag_error($sformatf("disp_vld %b with core_rdy %b", disp_vld, core_rdy));
      end
      if ((res_ack & (res_ack - 1'b1)) != 0 || (res_ack & ~res_vld) != 0) begin
         flag_error($sformatf("res_ack %b with res_vld %b", res_ack, res_vld));
      end
      for (int i = 0; i < NC; i++) begin
         if (res_ack[i]) begin
            got_ack[i] = 1'b1;
            busy[i]    = 1'b0;
            if (res[i].has_event) begin
               model_q.push_back(res[i].msg);
               n_acks++;
            end else begin
               n_null++;
            end
         end
         if (disp_vld[i]) check_dispatch(i);
      end
      if (done) begin
         if (done_seen) flag_error("done pulsed a second time");
         if (gvt <= end_time) flag_error($sformatf("done with gvt %0d", gvt));
         done_seen = 1'b1;
      end
   endtask

   task automatic run_cycle();
      @(negedge clk);
      update_cores();
      #(SAMPLE_OFS);
      check_outputs();
   endtask

   initial begin
      event_msg_u seed;
      rst_n    = 1'b0;
      core_rdy = '1;
      res_vld  = '0;
      res      = '0;
      busy     = '0;
      seen_lp  = '0;
      got_disp = '0;
      got_ack  = '0;
      last_gvt = '0;
      {err_cnt, n_disp, n_acks, n_null, n_ties, next_line} = '0;
      done_seen = 1'b0;
      aborted   = 1'b0;
      for (int i = 0; i < NC; i++) core_st[i] = 0;
      $readmemh("bench/event_trace.txt", trace_mem);
      end_time = trace_mem[0];
      n_lines  = trace_mem[1];
      if ($isunknown(trace_mem[0]) || n_lines < 1 || n_lines > MAX_LINES) begin
         $display("trace file is missing or has a bad line count");
         err_cnt++;
         aborted = 1'b1;
      end else if (end_time != `SCHED_END_TIME) begin
         flag_error($sformatf("trace end time %0d, design end time %0d",
                              end_time, `SCHED_END_TIME));
      end
      for (int i = 0; i < `SCHED_NUM_LP; i++) begin   // one time-zero seed per lp
         seed       = '0;
         seed.ev.pos = 1'b1;
         seed.ev.lp  = i;
         model_q.push_back(seed);
      end
      repeat (8) @(negedge clk);
      rst_n = 1'b1;
      #(SAMPLE_OFS);
      if (disp_vld != 0 || res_ack != 0 || done || gvt != 0) begin
         flag_error("outputs not at their reset values");
      end
      cycles = 0;
      while (!done_seen && !aborted && cycles < RUN_LIMIT) begin
         run_cycle();
         cycles++;
      end
      if (!done_seen && !aborted) begin
         $display("timeout, no done pulse within %0d cycles", RUN_LIMIT);
         err_cnt++;
      end
      for (int t = 0; t < TAIL && done_seen && !aborted; t++) run_cycle();
      if (n_disp + model_q.size() != `SCHED_NUM_LP + n_acks) begin
         flag_error($sformatf("%0d dispatches and %0d pending do not match %0d results",
                              n_disp, model_q.size(), n_acks));
      end
      if (n_null == 0) begin
         $display("no null result was acknowledged during the run");
         err_cnt++;
      end
      if (n_ties == 0) begin
         $display("no anti-message met a positive event of equal time");
         err_cnt++;
      end
      $display("dispatches %0d, results %0d, null results %0d, ties %0d, errors %0d",
               n_disp, n_acks, n_null, n_ties, err_cnt);
      if (err_cnt == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

// ==== bench/event_trace.txt ====
// first line: end time, number of scripted lines (hex)
// then per line: delay has_event pos lp_offset time_increment (hex)
00c8 000d
3 1 1 1 5
2 1 0 2 5
4 1 1 3 1e
1 1 1 1 28
5 0 1 0 4
2 1 1 5 14
3 1 0 6 1a
6 1 1 2 1a
1 1 1 7 24
2 1 1 1 20
3 1 0 3 20
2 1 1 4 2c
2 1 1 6 28

// ==== flist.f ====
+incdir+verilog
verilog/sched_pkg.sv
verilog/rr_arbiter.sv
verilog/event_queue.sv
verilog/core_tracker.sv
verilog/gvt_unit.sv
verilog/sched_ctrl.sv
verilog/event_sched.sv
bench/clk_gen.sv
bench/tb_event_sched.sv
